//--- hdl/sprite_consts.svh
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// sprite table geometry
`define SPRITE_COUNT 32 // slots in the table
`define COORD_W 10 // one screen coordinate, 0 to 1023
`define SPRITE_ID_W 6 // sprite identifier width

// a sprite covers a square of this edge, anchored at its top left pixel
`define SPRITE_SIZE 16

// result of one lookup
`define HIGH_COUNT 4 // entries in the high four result
`define NO_SPRITE_ID 0 // identifier of an empty slot

`endif

//--- hdl/sprite_pkg.sv
`include "sprite_consts.svh"

package sprite_pkg;

	typedef logic [`COORD_W-1:0] coord_t;

	// coordinate with one spare bit so anchor + 15 never wraps
	typedef logic [`COORD_W:0] coord_ext_t;

	typedef logic [`SPRITE_ID_W-1:0] sprite_id_t;

	typedef struct packed {
		coord_t h; // horizontal
		coord_t v; // vertical
	} pixel_pos_t;

	typedef struct packed {
		coord_t x; // anchor column
		coord_t y; // anchor row
		sprite_id_t id;
	} sprite_entry_t;

	// indexed by slot, slot 31 has the highest priority
	typedef sprite_entry_t [`SPRITE_COUNT-1:0] sprite_table_t;

endpackage

//--- hdl/finder_pkg.sv
`include "sprite_consts.svh"

package finder_pkg;

	import sprite_pkg::*;

	// one identifier per slot, zero where the sprite misses the pixel
	typedef sprite_id_t [`SPRITE_COUNT-1:0] found_vec_t;

	// entry 3 gets the first hit of the downward scan
	typedef sprite_id_t [`HIGH_COUNT-1:0] high_four_t;

endpackage

//--- hdl/sprite_hit_detect.sv
`timescale 1ns/10ps
`include "sprite_consts.svh"

module sprite_hit_detect
	import sprite_pkg::*;
	import finder_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic capture,
	input pixel_pos_t pos,
	input sprite_table_t sprites,
	output found_vec_t found
);

	coord_ext_t px;
	coord_ext_t py;
	logic [`SPRITE_COUNT-1:0] hit;
	found_vec_t hit_ids;

	assign px = {1'b0, pos.h};
	assign py = {1'b0, pos.v};

	// one box test per slot, all evaluated in parallel
	genvar i;
	generate
		for (i = 0; i < `SPRITE_COUNT; i++) begin : g_box
			coord_ext_t x_lo;
			coord_ext_t x_hi;
			coord_ext_t y_lo;
			coord_ext_t y_hi;

			assign x_lo = {1'b0, sprites[i].x};
			assign y_lo = {1'b0, sprites[i].y};
			assign x_hi = x_lo + coord_ext_t'(`SPRITE_SIZE - 1); // inclusive right edge
			assign y_hi = y_lo + coord_ext_t'(`SPRITE_SIZE - 1); // inclusive bottom edge

			assign hit[i] = (px >= x_lo) && (px <= x_hi) && (py >= y_lo) && (py <= y_hi);
			assign hit_ids[i] = hit[i] ? sprites[i].id : sprite_id_t'(`NO_SPRITE_ID);
		end
	endgenerate

	// found holds until the next capture
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			found <= '0;
		end else if (capture) begin
			found <= hit_ids;
		end
	end

endmodule

//--- hdl/high_four_select.sv
`timescale 1ns/10ps
`include "sprite_consts.svh"

module high_four_select
	import sprite_pkg::*;
	import finder_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input found_vec_t found,
	output logic capture,
	output logic ready,
	output high_four_t high_four
);

	localparam int SLOT_W = $clog2(`SPRITE_COUNT);
	localparam int FILL_W = $clog2(`HIGH_COUNT);

	typedef enum logic [1:0] {
		st_idle,
		st_capture,
		st_scan,
		st_done
	} state_t;

	state_t state;
	state_t state_next;
	logic [SLOT_W-1:0] slot; // slot under test, counts down
	logic [FILL_W-1:0] fill; // next result entry, counts down
	sprite_id_t cur_id;
	logic cur_hit;
	logic scan_last;
	logic accept;

	// start is only taken while idle, a start during a run is dropped
	assign accept = (state == st_idle) && start;

	assign cur_id = found[slot];
	assign cur_hit = (cur_id != sprite_id_t'(`NO_SPRITE_ID));

	// stop on the fourth fill or after slot 0
	assign scan_last = (cur_hit && (fill == '0)) || (slot == '0);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_next = st_capture;
				end
			end
			st_capture: begin
				state_next = st_scan; // found is valid from the next edge
			end
			st_scan: begin
				if (scan_last) begin
					state_next = st_done;
				end
			end
			st_done: begin
				state_next = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot <= '0;
			fill <= '0;
		end else if (state == st_capture) begin
			slot <= SLOT_W'(`SPRITE_COUNT - 1);
			fill <= FILL_W'(`HIGH_COUNT - 1);
		end else if (state == st_scan) begin
			if (!scan_last) begin
				slot <= slot - 1'b1;
			end
			if (cur_hit) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			high_four <= '0;
		end else if (accept) begin
			high_four <= '0; // no leftovers from the previous run
		end else if ((state == st_scan) && cur_hit) begin
			high_four[fill] <= cur_id;
		end
	end

	// ready is high while the FSM already sits in idle again
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			capture <= 1'b0;
			ready <= 1'b0;
		end else begin
			capture <= accept;
			ready <= (state == st_done);
		end
	end

endmodule

//--- hdl/sprite_finder_top.sv
`timescale 1ns/10ps
`include "sprite_consts.svh"

module sprite_finder_top
	import sprite_pkg::*;
	import finder_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input pixel_pos_t pos,
	input sprite_table_t sprites,
	output logic ready,
	output high_four_t high_four
);

	logic capture;
	found_vec_t found;

	// pos and sprites are sampled on the capture edge
	sprite_hit_detect u_hit_detect (
		.clk(clk),
		.rst(rst),
		.capture(capture),
		.pos(pos),
		.sprites(sprites),
		.found(found)
	);

	high_four_select u_select (
		.clk(clk),
		.rst(rst),
		.start(start),
		.found(found),
		.capture(capture),
		.ready(ready),
		.high_four(high_four)
	);

endmodule

//--- bench/sprite_finder_checker.sv
`timescale 1ns/10ps

module sprite_finder_checker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic capture,
	input logic ready
);

	int fail_count = 0;
	logic [7:0] since; // edges since the last accepted start
	logic running;
	logic taken; // start seen while the finder is idle

	// the finder is idle outside a run and again in the ready cycle
	assign taken = start && (!running || ready);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			since <= '0;
			running <= 1'b0;
		end else if (taken) begin
			since <= '0;
			running <= 1'b1;
		end else if (ready) begin
			running <= 1'b0;
		end else if (running && (since != 8'hff)) begin
			since <= since + 1'b1;
		end
	end

	a_ready_single: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else begin
			$error("ready high for two cycles in a row");
			fail_count++;
		end

	a_capture_follows: assert property (@(posedge clk) disable iff (rst) taken |=> capture)
		else begin
			$error("capture missing one edge after an accepted start");
			fail_count++;
		end

	a_capture_source: assert property (@(posedge clk) disable iff (rst) capture |-> $past(taken))
		else begin
			$error("capture without an accepted start");
			fail_count++;
		end

	// ready comes 3 to 34 edges after the accepting edge
	a_ready_window: assert property (@(posedge clk) disable iff (rst)
		ready |-> (running && (since >= 8'd3) && (since <= 8'd34)))
		else begin
			$error("ready outside its window after start");
			fail_count++;
		end

endmodule

//--- bench/sprite_finder_monitor.sv
`timescale 1ns/10ps
`include "sprite_consts.svh"

module sprite_finder_monitor
	import sprite_pkg::*;
	import finder_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input pixel_pos_t pos,
	input sprite_table_t sprites,
	input logic ready,
	input high_four_t high_four,
	output int pass_count,
	output int fail_count
);

	int edge_no = 0;
	int t0 = 0;
	int ready_edge = 0;
	int test_no = 0;
	int exp_n = 0;
	bit busy = 0;
	bit bad;
	high_four_t exp_high = '0;

	initial begin
		pass_count = 0;
		fail_count = 0;
	end

	// box test and downward scan, straight from the lookup rules
	function automatic void model(input pixel_pos_t p, input sprite_table_t t,
			output high_four_t h, output int n);
		int fill;
		int s;
		int hx;
		int vy;
		int ax;
		int ay;
		h = '0;
		n = 0;
		fill = `HIGH_COUNT - 1;
		hx = int'(p.h);
		vy = int'(p.v);
		for (s = `SPRITE_COUNT - 1; (s >= 0) && (fill >= 0); s--) begin
			n++;
			ax = int'(t[s].x);
			ay = int'(t[s].y);
			if ((hx >= ax) && (hx <= ax + `SPRITE_SIZE - 1) &&
					(vy >= ay) && (vy <= ay + `SPRITE_SIZE - 1) && (t[s].id != 0)) begin
				h[fill] = t[s].id;
				fill--;
			end
		end
	endfunction

	// inputs settle at the falling edge, so sample them here
	always @(posedge clk) begin
		edge_no++;
		if (rst) begin
			busy = 0;
		end else if (start && (!busy || (edge_no > ready_edge))) begin
			busy = 1;
			t0 = edge_no;
			ready_edge = 32'h4000_0000; // unknown until capture
		end else if (busy && (edge_no == t0 + 1)) begin
			model(pos, sprites, exp_high, exp_n);
			ready_edge = t0 + 2 + exp_n;
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (busy && (edge_no == ready_edge)) begin
				test_no++;
				bad = 0;
				if (ready !== 1'b1) begin
					$display("MISMATCH at %0t: ready expected 1 got %b", $time, ready);
					bad = 1;
				end
				if (high_four !== exp_high) begin
					$display("MISMATCH at %0t: high_four expected %h got %h",
						$time, exp_high, high_four);
					bad = 1;
				end
				if (bad) begin
					fail_count++;
					$display("test %0d failed", test_no);
				end else begin
					pass_count++;
					$display("test %0d ok: high_four %h after %0d slots",
						test_no, high_four, exp_n);
				end
			end else if (ready !== 1'b0) begin
				$display("MISMATCH at %0t: ready expected 0 got %b", $time, ready);
				fail_count++;
			end
		end
	end

endmodule

//--- bench/sprite_finder_tb.sv
`timescale 1ns/10ps
`include "sprite_consts.svh"

module sprite_finder_tb
	import sprite_pkg::*;
	import finder_pkg::*;
();

	localparam int KIND_FAR = 0; // nothing covers the pixel
	localparam int KIND_EDGE = 1;
	localparam int KIND_MANY = 2;
	localparam int KIND_PARTIAL = 3;
	localparam int KIND_RANDOM = 4;
	localparam int NO_TAG = 7; // no fill count expected

	typedef struct packed {
		pixel_pos_t pos;
		logic [2:0] kind;
		logic [3:0] delay; // falling edges before start, 0 means in the ready cycle
		logic poke; // extra start while busy
		logic [2:0] tag; // expected number of filled entries
	} case_t;

	logic clk;
	logic rst;
	logic start;
	pixel_pos_t pos;
	sprite_table_t sprites;
	logic ready;
	high_four_t high_four;

	case_t cases[$];
	logic [31:0] seed = 32'h20137a7e;
	int mon_pass;
	int mon_fail;
	int tb_errors = 0;
	int chk_fails;
	int waited;
	int filled;
	int k;
	int j;
	case_t c;
	pixel_pos_t p;
	sprite_table_t t;

	sprite_finder_top UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pos(pos),
		.sprites(sprites),
		.ready(ready),
		.high_four(high_four)
	);

	bind high_four_select sprite_finder_checker timing_chk (
		.clk(clk),
		.rst(rst),
		.start(start),
		.capture(capture),
		.ready(ready)
	);

	sprite_finder_monitor mon (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pos(pos),
		.sprites(sprites),
		.ready(ready),
		.high_four(high_four),
		.pass_count(mon_pass),
		.fail_count(mon_fail)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output int r);
		seed = xorshift(seed);
		r = int'(seed[30:0]);
	endtask

	task automatic make_stimulus(input case_t cs, output pixel_pos_t pp,
			output sprite_table_t tt);
		int i;
		int r;
		int bx;
		int by;
		pp = cs.pos;
		for (i = 0; i < `SPRITE_COUNT; i++) begin
			tt[i].x = '0;
			tt[i].y = '0;
			tt[i].id = sprite_id_t'(i + 1); // parked at the origin, away from the tests
		end
		case (int'(cs.kind))
			KIND_EDGE: begin
				tt[5] = '{x: 10'd100, y: 10'd200, id: 6'd9};
				tt[20] = '{x: 10'd1016, y: 10'd1016, id: 6'd33};
			end
			KIND_MANY: begin
				tt[31] = '{x: 10'd400, y: 10'd400, id: 6'd50};
				tt[28] = '{x: 10'd398, y: 10'd395, id: 6'd41};
				tt[20] = '{x: 10'd390, y: 10'd400, id: 6'd22};
				tt[15] = '{x: 10'd400, y: 10'd399, id: 6'd17};
				tt[10] = '{x: 10'd401, y: 10'd400, id: 6'd11};
				tt[3] = '{x: 10'd395, y: 10'd405, id: 6'd4};
			end
			KIND_PARTIAL: begin
				tt[12] = '{x: 10'd600, y: 10'd50, id: 6'd7};
				tt[2] = '{x: 10'd600, y: 10'd50, id: 6'd0}; // covers, but empty
				tt[0] = '{x: 10'd600, y: 10'd50, id: 6'd63};
			end
			KIND_RANDOM: begin
				next_rand(r);
				bx = r % 1000;
				next_rand(r);
				by = r % 1000;
				for (i = 0; i < `SPRITE_COUNT; i++) begin
					next_rand(r);
					tt[i].x = coord_t'(bx + r % 40);
					next_rand(r);
					tt[i].y = coord_t'(by + r % 40);
					next_rand(r);
					tt[i].id = sprite_id_t'(r % 64);
				end
				next_rand(r);
				pp.h = coord_t'(bx + r % 48);
				next_rand(r);
				pp.v = coord_t'(by + r % 48);
			end
			default: begin
			end
		endcase
	endtask

	task automatic add_case(input int h, input int v, input int kind, input int delay,
			input bit poke, input int tag);
		case_t cs;
		cs.pos.h = coord_t'(h);
		cs.pos.v = coord_t'(v);
		cs.kind = 3'(kind);
		cs.delay = 4'(delay);
		cs.poke = poke;
		cs.tag = 3'(tag);
		cases.push_back(cs);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		pos = '0;
		sprites = '0;

		add_case(500, 500, KIND_FAR, 2, 0, 0);
		add_case(100, 200, KIND_EDGE, 1, 0, 1); // corners hit
		add_case(115, 200, KIND_EDGE, 1, 0, 1);
		add_case(100, 215, KIND_EDGE, 1, 0, 1);
		add_case(115, 215, KIND_EDGE, 1, 0, 1);
		add_case(99, 200, KIND_EDGE, 1, 0, 0); // one past each edge
		add_case(116, 200, KIND_EDGE, 1, 0, 0);
		add_case(100, 199, KIND_EDGE, 1, 0, 0);
		add_case(100, 216, KIND_EDGE, 1, 0, 0);
		add_case(1016, 1016, KIND_EDGE, 1, 0, 1);
		add_case(1023, 1023, KIND_EDGE, 1, 0, 1);
		add_case(1015, 1020, KIND_EDGE, 1, 0, 0);
		add_case(405, 410, KIND_MANY, 1, 0, 4);
		add_case(610, 60, KIND_PARTIAL, 0, 0, 2);
		add_case(402, 405, KIND_MANY, 3, 1, 4);
		add_case(500, 500, KIND_FAR, 0, 0, 0); // old result must be gone
		for (k = 0; k < 8; k++) begin
			add_case(0, 0, KIND_RANDOM, k % 3, 0, NO_TAG);
		end

		repeat (5) @(negedge clk);
		rst = 1'b0;

		for (k = 0; k < cases.size(); k++) begin
			c = cases[k];
			for (j = 0; j < int'(c.delay); j++) begin
				@(negedge clk);
			end
			make_stimulus(c, p, t);
			pos = p;
			sprites = t;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			if (c.poke) begin
				repeat (4) @(negedge clk);
				start = 1'b1; // FSM is scanning, this pulse must be dropped
				@(negedge clk);
				start = 1'b0;
			end
			waited = 0;
			while ((ready !== 1'b1) && (waited < 100)) begin
				@(negedge clk);
				waited++;
			end
			if (ready !== 1'b1) begin
				$display("ERROR: test %0d got no ready within 100 cycles", k + 1);
				$display("Some tests failed");
				$finish;
			end
			filled = 0;
			for (j = 0; j < `HIGH_COUNT; j++) begin
				if (high_four[j] != sprite_id_t'(`NO_SPRITE_ID)) begin
					filled++;
				end
			end
			if ((int'(c.tag) != NO_TAG) && (filled != int'(c.tag))) begin
				$display("MISMATCH at %0t: high_four filled entries expected %0d got %0d",
					$time, c.tag, filled);
				tb_errors++;
			end
		end

		repeat (3) @(negedge clk); // let the monitor see ready fall
		chk_fails = UUT.u_select.timing_chk.fail_count;
		$display("tests run %0d, monitor passed %0d, monitor failed %0d, other errors %0d",
			cases.size(), mon_pass, mon_fail, tb_errors + chk_fails);
		if ((mon_fail == 0) && (tb_errors == 0) && (chk_fails == 0) &&
				(mon_pass == cases.size())) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/sprite_pkg.sv
hdl/finder_pkg.sv
hdl/sprite_hit_detect.sv
hdl/high_four_select.sv
hdl/sprite_finder_top.sv
bench/sprite_finder_checker.sv
bench/sprite_finder_monitor.sv
bench/sprite_finder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite finder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module sprite_finder_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vsprite_finder_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
